//--- files.f
hw/trdb_pkg.sv
hw/trdb_field_if.sv
hw/trdb_field_select.sv
hw/trdb_range_cmp.sv
hw/trdb_qualify.sv
hw/trdb_filter.sv
verif/trdb_filter_chk.sv
verif/tb_trdb_filter.sv

//--- Makefile
TOP := tb_trdb_filter
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module trdb_filter hw/trdb_pkg.sv hw/trdb_field_if.sv \
		hw/trdb_field_select.sv hw/trdb_range_cmp.sv hw/trdb_qualify.sv \
		hw/trdb_filter.sv
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/tb_trdb_filter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for trdb_filter, fields kept widened to XLEN
// inputs change on falling edges, outputs read there too
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module tb_trdb_filter;

    timeunit 1ns;
    timeprecision 1ps;

    import trdb_pkg::*;

    localparam int unsigned W = trdb_pkg::XLEN;
    localparam int DRAIN_LIMIT = 100;

    typedef struct packed {
        logic                         te;
        logic [NUM_FIELDS-1:0]        en;
        logic [NUM_FIELDS-1:0]        mode;
        logic [NUM_FIELDS-1:0][W-1:0] val;
        logic [NUM_FIELDS-1:0][W-1:0] up;
        logic [NUM_FIELDS-1:0][W-1:0] lo;
        logic [NUM_FIELDS-1:0][W-1:0] mt;
    } pkt_t;

    logic clk;
    logic rst_n;
    logic trace_enable;
    logic cause_filter, tvec_filter, tval_filter, priv_filter, iaddr_filter;
    logic cause_mode, tvec_mode, tval_mode, priv_mode, iaddr_mode;
    logic [CAUSE_LEN-1:0] cause, upper_cause, lower_cause, match_cause;
    logic [W-1:2] tvec, upper_tvec, lower_tvec, match_tvec;
    logic [W-1:0] tval, upper_tval, lower_tval, match_tval;
    logic [PRIV_LEN-1:0] priv, upper_priv, lower_priv, match_priv;
    logic [W-1:0] iaddr, upper_iaddr, lower_iaddr, match_iaddr;
    logic nc_qualified;

    logic [31:0] rng = 32'h2480;
    int edge_cnt = 0;
    int errors = 0;
    int checks = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int err_mark = 0;
    bit timed_out = 1'b0;
    logic exp_q [$];
    int due_q [$];

    trdb_filter #(.XLEN(W)) u_trdb_filter (
        .clk(clk), .rst_n_i(rst_n), .trace_enable_i(trace_enable),
        .cause_filter_i(cause_filter), .upper_cause_i(upper_cause),
        .lower_cause_i(lower_cause), .match_cause_i(match_cause),
        .cause_mode_i(cause_mode), .cause_i(cause),
        .tvec_filter_i(tvec_filter), .upper_tvec_i(upper_tvec),
        .lower_tvec_i(lower_tvec), .match_tvec_i(match_tvec),
        .tvec_mode_i(tvec_mode), .tvec_i(tvec),
        .tval_filter_i(tval_filter), .upper_tval_i(upper_tval),
        .lower_tval_i(lower_tval), .match_tval_i(match_tval),
        .tval_mode_i(tval_mode), .tval_i(tval),
        .priv_lvl_filter_i(priv_filter), .upper_priv_lvl_i(upper_priv),
        .lower_priv_lvl_i(lower_priv), .match_priv_lvl_i(match_priv),
        .priv_lvl_mode_i(priv_mode), .priv_lvl_i(priv),
        .iaddr_filter_i(iaddr_filter), .upper_iaddr_i(upper_iaddr),
        .lower_iaddr_i(lower_iaddr), .match_iaddr_i(match_iaddr),
        .iaddr_mode_i(iaddr_mode), .iaddr_i(iaddr),
        .nc_qualified_o(nc_qualified)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // legal bits of each widened field
    function automatic logic [W-1:0] field_mask(input int k);
        if (k == FIELD_CAUSE) return W'(32'h1f);
        if (k == FIELD_TVEC) return {{(W-2){1'b1}}, 2'b00};
        if (k == FIELD_PRIV) return W'(32'h3);
        return '1;
    endfunction

    function automatic logic expected_qualified(input pkt_t p);
        logic ok;
        logic pass;
        ok = p.te;
        for (int k = 0; k < NUM_FIELDS; k++) begin
            if (!p.en[k]) begin
                pass = 1'b1;
            end else if (p.mode[k]) begin
                pass = (p.lo[k] <= p.val[k]) && (p.val[k] <= p.up[k]);
            end else begin
                pass = (p.val[k] == p.mt[k]);
            end
            ok = ok & pass;
        end
        return ok;
    endfunction

    function automatic pkt_t idle_pkt(input logic te);
        pkt_t p;
        p = '0;
        p.te = te;
        return p;
    endfunction

    function pkt_t rand_pkt();
        pkt_t p;
        logic [31:0] r;
        logic [W-1:0] m;
        p = '0;
        p.te = (next_rand() % 8) != 0;
        for (int k = 0; k < NUM_FIELDS; k++) begin
            m = field_mask(k);
            r = next_rand();
            p.en[k] = r[0];
            p.mode[k] = r[1];
            p.val[k] = next_rand() & m;
            if (r[2]) begin
                // bounds close around the value
                p.lo[k] = (p.val[k] - (next_rand() & m & W'(32'h1f))) & m;
                p.up[k] = (p.val[k] + (next_rand() & m & W'(32'h1f))) & m;
            end else begin
                p.lo[k] = next_rand() & m;
                p.up[k] = next_rand() & m;
            end
            p.mt[k] = (r[4:3] == 2'b00) ? p.val[k] : (next_rand() & m);
        end
        return p;
    endfunction

    task automatic apply_pkt(input pkt_t p);
        trace_enable = p.te;
        cause_filter = p.en[FIELD_CAUSE];
        cause_mode   = p.mode[FIELD_CAUSE];
        cause        = p.val[FIELD_CAUSE][CAUSE_LEN-1:0];
        upper_cause  = p.up[FIELD_CAUSE][CAUSE_LEN-1:0];
        lower_cause  = p.lo[FIELD_CAUSE][CAUSE_LEN-1:0];
        match_cause  = p.mt[FIELD_CAUSE][CAUSE_LEN-1:0];
        tvec_filter  = p.en[FIELD_TVEC];
        tvec_mode    = p.mode[FIELD_TVEC];
        tvec         = p.val[FIELD_TVEC][W-1:2];
        upper_tvec   = p.up[FIELD_TVEC][W-1:2];
        lower_tvec   = p.lo[FIELD_TVEC][W-1:2];
        match_tvec   = p.mt[FIELD_TVEC][W-1:2];
        tval_filter  = p.en[FIELD_TVAL];
        tval_mode    = p.mode[FIELD_TVAL];
        tval         = p.val[FIELD_TVAL];
        upper_tval   = p.up[FIELD_TVAL];
        lower_tval   = p.lo[FIELD_TVAL];
        match_tval   = p.mt[FIELD_TVAL];
        priv_filter  = p.en[FIELD_PRIV];
        priv_mode    = p.mode[FIELD_PRIV];
        priv         = p.val[FIELD_PRIV][PRIV_LEN-1:0];
        upper_priv   = p.up[FIELD_PRIV][PRIV_LEN-1:0];
        lower_priv   = p.lo[FIELD_PRIV][PRIV_LEN-1:0];
        match_priv   = p.mt[FIELD_PRIV][PRIV_LEN-1:0];
        iaddr_filter = p.en[FIELD_IADDR];
        iaddr_mode   = p.mode[FIELD_IADDR];
        iaddr        = p.val[FIELD_IADDR];
        upper_iaddr  = p.up[FIELD_IADDR];
        lower_iaddr  = p.lo[FIELD_IADDR];
        match_iaddr  = p.mt[FIELD_IADDR];
    endtask

    // one packet per falling edge, result due QUAL_LATENCY edges on
    task automatic send_pkt(input pkt_t p);
        @(negedge clk);
        apply_pkt(p);
        exp_q.push_back(expected_qualified(p));
        due_q.push_back(edge_cnt + QUAL_LATENCY);
    endtask

    task automatic check_qualified(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: nc_qualified_o got %b expected %b",
                     $time, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (due_q.size() > 0 && due_q[0] == edge_cnt) begin
            check_qualified(nc_qualified, exp_q[0]);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    task automatic wait_drain();
        int n;
        n = 0;
        while (due_q.size() > 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (due_q.size() > 0) begin
            $display("timeout: expected results still pending after %0d cycles", n);
            timed_out = 1'b1;
        end
    endtask

    task automatic end_test(input string name);
        wait_drain();
        if (timed_out) begin
            tests_bad++;
            $display("test %s: stopped by timeout", name);
        end else if (errors == err_mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        pkt_t p;
        logic [W-1:0] m;
        logic [W-1:0] step;
        rst_n = 1'b0;
        apply_pkt(idle_pkt(1'b1));

        // reset, then the first edges after release
        repeat (2) begin
            @(negedge clk);
            check_qualified(nc_qualified, 1'b0);
        end
        rst_n = 1'b1;
        check_qualified(nc_qualified, 1'b0);
        repeat (QUAL_LATENCY - 1) begin
            @(negedge clk);
            check_qualified(nc_qualified, 1'b0);
        end
        end_test("reset");

        if (!timed_out) begin
            for (int i = 0; i < 40; i++) begin
                send_pkt(idle_pkt((next_rand() % 2) != 0));
            end
            end_test("trace_enable");
        end

        if (!timed_out) begin
            for (int k = 0; k < NUM_FIELDS; k++) begin
                m = field_mask(k);
                step = m & (~m + W'(1));
                p = idle_pkt(1'b1);
                p.en[k] = 1'b1;
                p.val[k] = next_rand() & m;
                p.mt[k] = p.val[k];
                send_pkt(p);
                p.mt[k] = p.val[k] ^ step;
                send_pkt(p);
            end
            end_test("match_mode");
        end

        if (!timed_out) begin
            for (int k = 0; k < NUM_FIELDS; k++) begin
                m = field_mask(k);
                step = m & (~m + W'(1));
                p = idle_pkt(1'b1);
                p.en[k] = 1'b1;
                p.mode[k] = 1'b1;
                p.lo[k] = step;
                p.up[k] = m - step;
                p.val[k] = p.lo[k];
                send_pkt(p);
                p.val[k] = p.up[k];
                send_pkt(p);
                p.val[k] = p.lo[k] - step;
                send_pkt(p);
                p.val[k] = p.up[k] + step;
                send_pkt(p);
            end
            end_test("range_mode");
        end

        if (!timed_out) begin
            for (int i = 0; i < 500; i++) begin
                send_pkt(rand_pkt());
            end
            end_test("random_combined");
        end

        $display("tests ok %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_ok, tests_bad, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/trdb_filter_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound to trdb_filter, watches only its top ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module trdb_filter_chk (
    input wire logic clk,
    input wire logic rst_n_i,
    input wire logic trace_enable_i,
    input wire logic nc_qualified_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import trdb_pkg::*;

    // output held low while reset is asserted
    a_reset_low: assert property (@(posedge clk) !rst_n_i |-> !nc_qualified_o)
        else $error("nc_qualified_o high during reset");

    // packet without trace enable never qualifies
    a_te_low: assert property (@(posedge clk) disable iff (!rst_n_i)
        !trace_enable_i |-> ##QUAL_LATENCY !nc_qualified_o)
        else $error("nc_qualified_o high although trace_enable_i was low");

    a_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(nc_qualified_o))
        else $error("nc_qualified_o unknown after reset");

endmodule

bind trdb_filter trdb_filter_chk u_chk (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .trace_enable_i (trace_enable_i),
    .nc_qualified_o (nc_qualified_o)
);

`default_nettype wire

//--- hw/trdb_filter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trace qualification filter, new packet every cycle
// result appears QUAL_LATENCY edges after its inputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module trdb_filter #(
    parameter int unsigned XLEN = trdb_pkg::XLEN
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           trace_enable_i,
    // cause
    input  logic                           cause_filter_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0] upper_cause_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0] lower_cause_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0] match_cause_i,
    input  logic                           cause_mode_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0] cause_i,
    // tvec
    input  logic                           tvec_filter_i,
    input  logic [XLEN-1:2]                upper_tvec_i,
    input  logic [XLEN-1:2]                lower_tvec_i,
    input  logic [XLEN-1:2]                match_tvec_i,
    input  logic                           tvec_mode_i,
    input  logic [XLEN-1:2]                tvec_i,
    // tval
    input  logic                           tval_filter_i,
    input  logic [XLEN-1:0]                upper_tval_i,
    input  logic [XLEN-1:0]                lower_tval_i,
    input  logic [XLEN-1:0]                match_tval_i,
    input  logic                           tval_mode_i,
    input  logic [XLEN-1:0]                tval_i,
    // privilege level
    input  logic                           priv_lvl_filter_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]  upper_priv_lvl_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]  lower_priv_lvl_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]  match_priv_lvl_i,
    input  logic                           priv_lvl_mode_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]  priv_lvl_i,
    // instruction address
    input  logic                           iaddr_filter_i,
    input  logic [XLEN-1:0]                upper_iaddr_i,
    input  logic [XLEN-1:0]                lower_iaddr_i,
    input  logic [XLEN-1:0]                match_iaddr_i,
    input  logic                           iaddr_mode_i,
    input  logic [XLEN-1:0]                iaddr_i,
    output logic                           nc_qualified_o
);

    import trdb_pkg::*;

    logic                  te;
    logic [NUM_FIELDS-1:0] hit;

    trdb_field_if #(.XLEN(XLEN)) field_if [NUM_FIELDS] ();

    // port names match the top level one to one
    trdb_field_select #(
        .XLEN(XLEN)
    ) u_field_select (
        .*,
        .fields_o (field_if),
        .te_o     (te)
    );

    for (genvar k = 0; k < NUM_FIELDS; k++) begin : g_cmp
        trdb_range_cmp #(
            .XLEN(XLEN)
        ) u_range_cmp (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .field_i (field_if[k]),
            .hit_o   (hit[k])
        );
    end

    trdb_qualify u_qualify (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .te_i           (te),
        .hit_i          (hit),
        .nc_qualified_o (nc_qualified_o)
    );

endmodule

`default_nettype wire

//--- hw/trdb_qualify.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// last stage: te delayed one edge to meet the hits,
// then ANDed with all of them and registered
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module trdb_qualify (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            te_i,
    input  logic [trdb_pkg::NUM_FIELDS-1:0] hit_i,
    output logic                            nc_qualified_o
);

    logic te_q;
    logic qual_d;
    logic qual_q;

    // te_q and hit_i belong to the same packet
    assign qual_d = te_q & (&hit_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            te_q   <= 1'b0;
            qual_q <= 1'b0;
        end else begin
            te_q   <= te_i;
            qual_q <= qual_d;
        end
    end

    assign nc_qualified_o = qual_q;

endmodule

`default_nettype wire

//--- hw/trdb_range_cmp.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-field judge, unsigned compares only
// hit is registered, one edge after the field
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module trdb_range_cmp #(
    parameter int unsigned XLEN = trdb_pkg::XLEN
) (
    input  logic      clk,
    input  logic      rst_n_i,
    trdb_field_if.snk field_i,
    output logic      hit_o
);

    logic in_range;
    logic is_match;
    logic hit_d;
    logic hit_q;

    // bounds are inclusive
    assign in_range = (field_i.value >= field_i.lower) &&
                      (field_i.value <= field_i.upper);
    assign is_match = (field_i.value == field_i.match);

    always_comb begin
        if (!field_i.filter_en) begin
            // disabled field never blocks
            hit_d = 1'b1;
        end else if (field_i.mode) begin
            hit_d = in_range;
        end else begin
            hit_d = is_match;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit_d;
        end
    end

    assign hit_o = hit_q;

endmodule

`default_nettype wire

//--- hw/trdb_field_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// first stage: registers packet and settings, widens
// cause, tvec and priv to XLEN, no handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module trdb_field_select #(
    parameter int unsigned XLEN = trdb_pkg::XLEN
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           trace_enable_i,
    // cause
    input  logic                           cause_filter_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0] upper_cause_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0] lower_cause_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0] match_cause_i,
    input  logic                           cause_mode_i,
    input  logic [trdb_pkg::CAUSE_LEN-1:0] cause_i,
    // tvec, word aligned
    input  logic                           tvec_filter_i,
    input  logic [XLEN-1:2]                upper_tvec_i,
    input  logic [XLEN-1:2]                lower_tvec_i,
    input  logic [XLEN-1:2]                match_tvec_i,
    input  logic                           tvec_mode_i,
    input  logic [XLEN-1:2]                tvec_i,
    // tval
    input  logic                           tval_filter_i,
    input  logic [XLEN-1:0]                upper_tval_i,
    input  logic [XLEN-1:0]                lower_tval_i,
    input  logic [XLEN-1:0]                match_tval_i,
    input  logic                           tval_mode_i,
    input  logic [XLEN-1:0]                tval_i,
    // privilege level
    input  logic                           priv_lvl_filter_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]  upper_priv_lvl_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]  lower_priv_lvl_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]  match_priv_lvl_i,
    input  logic                           priv_lvl_mode_i,
    input  logic [trdb_pkg::PRIV_LEN-1:0]  priv_lvl_i,
    // instruction address
    input  logic                           iaddr_filter_i,
    input  logic [XLEN-1:0]                upper_iaddr_i,
    input  logic [XLEN-1:0]                lower_iaddr_i,
    input  logic [XLEN-1:0]                match_iaddr_i,
    input  logic                           iaddr_mode_i,
    input  logic [XLEN-1:0]                iaddr_i,
    trdb_field_if.src                      fields_o [trdb_pkg::NUM_FIELDS],
    output logic                           te_o
);

    import trdb_pkg::*;

    logic [NUM_FIELDS-1:0][XLEN-1:0] value_d;
    logic [NUM_FIELDS-1:0][XLEN-1:0] upper_d;
    logic [NUM_FIELDS-1:0][XLEN-1:0] lower_d;
    logic [NUM_FIELDS-1:0][XLEN-1:0] match_d;
    logic [NUM_FIELDS-1:0]           en_d;
    logic [NUM_FIELDS-1:0]           mode_d;

    logic [NUM_FIELDS-1:0][XLEN-1:0] value_q;
    logic [NUM_FIELDS-1:0][XLEN-1:0] upper_q;
    logic [NUM_FIELDS-1:0][XLEN-1:0] lower_q;
    logic [NUM_FIELDS-1:0][XLEN-1:0] match_q;
    logic [NUM_FIELDS-1:0]           en_q;
    logic [NUM_FIELDS-1:0]           mode_q;
    logic                            te_q;

    // widen and order by field_idx_e
    always_comb begin
        value_d[FIELD_CAUSE] = XLEN'(cause_i);
        upper_d[FIELD_CAUSE] = XLEN'(upper_cause_i);
        lower_d[FIELD_CAUSE] = XLEN'(lower_cause_i);
        match_d[FIELD_CAUSE] = XLEN'(match_cause_i);
        en_d[FIELD_CAUSE]    = cause_filter_i;
        mode_d[FIELD_CAUSE]  = cause_mode_i;

        // tvec keeps its bit positions, low two bits zero
        value_d[FIELD_TVEC]  = {tvec_i, 2'b00};
        upper_d[FIELD_TVEC]  = {upper_tvec_i, 2'b00};
        lower_d[FIELD_TVEC]  = {lower_tvec_i, 2'b00};
        match_d[FIELD_TVEC]  = {match_tvec_i, 2'b00};
        en_d[FIELD_TVEC]     = tvec_filter_i;
        mode_d[FIELD_TVEC]   = tvec_mode_i;

        value_d[FIELD_TVAL]  = tval_i;
        upper_d[FIELD_TVAL]  = upper_tval_i;
        lower_d[FIELD_TVAL]  = lower_tval_i;
        match_d[FIELD_TVAL]  = match_tval_i;
        en_d[FIELD_TVAL]     = tval_filter_i;
        mode_d[FIELD_TVAL]   = tval_mode_i;

        value_d[FIELD_PRIV]  = XLEN'(priv_lvl_i);
        upper_d[FIELD_PRIV]  = XLEN'(upper_priv_lvl_i);
        lower_d[FIELD_PRIV]  = XLEN'(lower_priv_lvl_i);
        match_d[FIELD_PRIV]  = XLEN'(match_priv_lvl_i);
        en_d[FIELD_PRIV]     = priv_lvl_filter_i;
        mode_d[FIELD_PRIV]   = priv_lvl_mode_i;

        value_d[FIELD_IADDR] = iaddr_i;
        upper_d[FIELD_IADDR] = upper_iaddr_i;
        lower_d[FIELD_IADDR] = lower_iaddr_i;
        match_d[FIELD_IADDR] = match_iaddr_i;
        en_d[FIELD_IADDR]    = iaddr_filter_i;
        mode_d[FIELD_IADDR]  = iaddr_mode_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            value_q <= '0;
            upper_q <= '0;
            lower_q <= '0;
            match_q <= '0;
            en_q    <= '0;
            mode_q  <= '0;
            te_q    <= 1'b0;
        end else begin
            value_q <= value_d;
            upper_q <= upper_d;
            lower_q <= lower_d;
            match_q <= match_d;
            en_q    <= en_d;
            mode_q  <= mode_d;
            te_q    <= trace_enable_i;
        end
    end

    for (genvar k = 0; k < NUM_FIELDS; k++) begin : g_out
        assign fields_o[k].value     = value_q[k];
        assign fields_o[k].filter_en = en_q[k];
        assign fields_o[k].mode      = mode_q[k];
        assign fields_o[k].upper     = upper_q[k];
        assign fields_o[k].lower     = lower_q[k];
        assign fields_o[k].match     = match_q[k];
    end

    assign te_o = te_q;

endmodule

`default_nettype wire

//--- hw/trdb_field_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one trace field, already widened to XLEN bits,
// together with its filter setting
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

interface trdb_field_if #(
    parameter int unsigned XLEN = trdb_pkg::XLEN
);

    logic [XLEN-1:0] value;
    logic            filter_en;
    // 1: range mode, 0: match mode
    logic            mode;
    logic [XLEN-1:0] upper;
    logic [XLEN-1:0] lower;
    logic [XLEN-1:0] match;

    modport src (
        output value, filter_en, mode, upper, lower, match
    );

    modport snk (
        input value, filter_en, mode, upper, lower, match
    );

endinterface

`default_nettype wire

//--- hw/trdb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and field order shared by the trace filter
// QUAL_LATENCY must match the register stages in trdb_filter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package trdb_pkg;

    // data and address width, default for the top level
    localparam int unsigned XLEN = 32;

    // narrow trace fields
    localparam int unsigned CAUSE_LEN = 5;
    localparam int unsigned PRIV_LEN  = 2;

    // number of fields that have a filter setting
    localparam int unsigned NUM_FIELDS = 5;

    // index of each field in the hit vector and the interface array
    typedef enum logic [2:0] {
        FIELD_CAUSE = 3'd0,
        FIELD_TVEC  = 3'd1,
        FIELD_TVAL  = 3'd2,
        FIELD_PRIV  = 3'd3,
        FIELD_IADDR = 3'd4
    } field_idx_e;

    // edges from packet inputs to nc_qualified_o
    // select stage, compare stage, qualify stage
    localparam int unsigned QUAL_LATENCY = 3;

endpackage

`default_nettype wire
